/* lsu_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module lsu_ctrl_regs (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   cfg_cyc,
    input  logic                   cfg_stb,
    input  logic                   cfg_we,
    input  logic [`LSU_CFG_AW-1:0] cfg_adr,    // word offset
    input  logic [`LSU_XLEN-1:0]   cfg_dat_w,
    output logic [`LSU_XLEN-1:0]   cfg_dat_r,
    output logic                   cfg_ack,
    input  logic                   fault_pulse,
    input  logic [`LSU_XLEN-1:0]   fault_addr,
    output lsu_pkg::lsu_window_t   win
);

    logic                 req;        // new access, not yet acked
    logic [`LSU_XLEN-1:0] base_q;
    logic [`LSU_XLEN-1:0] mask_q;
    logic                 check_en_q;
    logic [`LSU_XLEN-1:0] fcnt_q;     // saturating fault count
    logic [`LSU_XLEN-1:0] faddr_q;

    // ack low for a cycle between accesses
    assign req = cfg_cyc & cfg_stb & ~cfg_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_ack    <= 1'b0;
            base_q     <= '0;
            mask_q     <= '0;
            check_en_q <= 1'b0;   // window check off after reset
            fcnt_q     <= '0;
            faddr_q    <= '0;
        end else begin
            cfg_ack <= req;
            if (req && cfg_we) begin
                case (cfg_adr)
                    `LSU_CFG_BASE: base_q     <= cfg_dat_w;
                    `LSU_CFG_MASK: mask_q     <= cfg_dat_w;
                    `LSU_CFG_CTRL: check_en_q <= cfg_dat_w[0];
                    default: ;                      // fcnt and faddr ignore writes
                endcase
            end
            if (fault_pulse) begin
                if (!(&fcnt_q)) begin
                    fcnt_q <= fcnt_q + 1;           // stops at all ones
                end
                faddr_q <= fault_addr;
            end
        end
    end

    // read data registered with the ack
    always_ff @(posedge clk) begin
        if (req && !cfg_we) begin
            case (cfg_adr)
                `LSU_CFG_BASE:  cfg_dat_r <= base_q;
                `LSU_CFG_MASK:  cfg_dat_r <= mask_q;
                `LSU_CFG_CTRL:  cfg_dat_r <= {{(`LSU_XLEN-1){1'b0}}, check_en_q};
                `LSU_CFG_FCNT:  cfg_dat_r <= fcnt_q;
                `LSU_CFG_FADDR: cfg_dat_r <= faddr_q;
                default:        cfg_dat_r <= '0;   // unmapped reads as 0
            endcase
        end
    end

    assign win = '{
        base:     base_q,
        mask:     mask_q,
        check_en: check_en_q
    };

endmodule

`default_nettype wire

/* lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// datapath widths
`define LSU_XLEN    32  // data and address
`define LSU_RIDX    5   // register index
`define LSU_EXPW    7   // exception code
`define LSU_SELW    4   // byte lanes per word

// config bus word offsets
`define LSU_CFG_AW     3
`define LSU_CFG_BASE   3'd0  // window base
`define LSU_CFG_MASK   3'd1  // window mask
`define LSU_CFG_CTRL   3'd2  // bit 0 is check enable
`define LSU_CFG_FCNT   3'd3  // fault count, read only
`define LSU_CFG_FADDR  3'd4  // last fault address, read only

`endif

/* lsu_pkg.sv */
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

    // access size, same coding as the execute stage
    typedef enum logic [1:0] {
        W_BYTE = 2'b00,
        W_HALF = 2'b01,
        W_WORD = 2'b10
    } mem_width_e;

    // codes raised here, upstream codes pass through untouched
    typedef enum logic [`LSU_EXPW-1:0] {
        EXC_NONE = 7'h00,
        EXC_ALE  = 7'h09,  // misaligned
        EXC_PME  = 7'h0a,  // outside protection window
        EXC_BUS  = 7'h0b   // bus error reply
    } exc_code_e;

    typedef enum logic [1:0] {
        WB_IDLE  = 2'b00,
        WB_CYCLE = 2'b01,
        WB_DONE  = 2'b10
    } wb_state_e;

    // operation from execute
    typedef struct packed {
        logic                 en;
        logic                 write;
        mem_width_e           width;
        logic                 sign;   // sign extend loads
        logic [`LSU_RIDX-1:0] rd;
        logic [`LSU_XLEN-1:0] base;
        logic [`LSU_XLEN-1:0] imm;
        logic [`LSU_XLEN-1:0] wdata;
        logic [`LSU_EXPW-1:0] exp;    // incoming exception
    } mem_op_t;

    // formed bus access
    typedef struct packed {
        logic                 go;     // bus access wanted now
        logic                 write;
        logic [`LSU_XLEN-1:0] addr;
        logic [`LSU_SELW-1:0] sel;
        logic [`LSU_XLEN-1:0] wdata;  // already in its lanes
        logic [`LSU_EXPW-1:0] exp;
    } mem_access_t;

    // write-back bundle
    typedef struct packed {
        logic                 valid;
        logic [`LSU_RIDX-1:0] rd;
        logic [`LSU_XLEN-1:0] data;
        logic [`LSU_EXPW-1:0] exp;
        logic [`LSU_XLEN-1:0] badv;
    } mem_result_t;

    // protection window from the config block
    typedef struct packed {
        logic [`LSU_XLEN-1:0] base;
        logic [`LSU_XLEN-1:0] mask;
        logic                 check_en;
    } lsu_window_t;

endpackage

`default_nettype wire

/* mem_addr_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module mem_addr_stage (
    input  lsu_pkg::mem_op_t     op,
    input  lsu_pkg::lsu_window_t win,
    input  logic                 busy,  // port still finishing this op
    output lsu_pkg::mem_access_t acc
);
    import lsu_pkg::*;

    logic [`LSU_XLEN-1:0] ea;         // effective address
    logic [1:0]           off;        // byte offset in word
    logic                 misaligned;
    logic                 win_fault;
    logic [`LSU_SELW-1:0] sel_base;   // enables before the shift
    logic [`LSU_SELW-1:0] sel;
    logic [`LSU_XLEN-1:0] wdata_rep;
    logic [`LSU_EXPW-1:0] exp_n;

    assign ea  = op.base + op.imm;
    assign off = ea[1:0];

    // size decode
    always_comb begin
        misaligned = 1'b0;
        sel_base   = 4'b1111;
        wdata_rep  = op.wdata;
        case (op.width)
            W_BYTE: begin
                sel_base  = 4'b0001;
                wdata_rep = {4{op.wdata[7:0]}};   // byte in every lane
            end
            W_HALF: begin
                sel_base   = 4'b0011;
                wdata_rep  = {2{op.wdata[15:0]}};
                misaligned = off[0];
            end
            default: begin
                misaligned = |off;              // word needs off == 0
            end
        endcase
    end

    // lanes picked by low address bits
    assign sel = sel_base << off;

    // window hit means masked address equals base
    assign win_fault = win.check_en & ((ea & win.mask) != win.base);

    // upstream code first, then alignment, then window
    always_comb begin
        if (!op.en) begin
            exp_n = EXC_NONE;
        end else if (op.exp != EXC_NONE) begin
            exp_n = op.exp;
        end else if (misaligned) begin
            exp_n = EXC_ALE;
        end else if (win_fault) begin
            exp_n = EXC_PME;
        end else begin
            exp_n = EXC_NONE;
        end
    end

    assign acc = '{
        go:    op.en & (exp_n == EXC_NONE) & ~busy,  // no reissue of a held op
        write: op.write,
        addr:  ea,
        sel:   sel,
        wdata: wdata_rep,
        exp:   exp_n
    };

endmodule

`default_nettype wire

/* mem_stage.f */
+incdir+.
lsu_pkg.sv
mem_addr_stage.sv
wb_data_port.sv
mem_wb_stage.sv
lsu_ctrl_regs.sv
mem_stage_top.sv
tb_mem_stage_assertions.sv
tb_mem_stage.sv

/* mem_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module mem_stage_top (
    input  logic                   clk,
    input  logic                   arst_n,
    // pipeline
    input  lsu_pkg::mem_op_t       op,
    output lsu_pkg::mem_result_t   res,
    output logic                   stall,
    // data bus master
    output logic                   cyc,
    output logic                   stb,
    output logic                   we,
    output logic [`LSU_XLEN-1:0]   adr,
    output logic [`LSU_SELW-1:0]   sel,
    output logic [`LSU_XLEN-1:0]   dat_w,
    input  logic [`LSU_XLEN-1:0]   dat_r,
    input  logic                   ack,
    input  logic                   err,
    // config bus slave
    input  logic                   cfg_cyc,
    input  logic                   cfg_stb,
    input  logic                   cfg_we,
    input  logic [`LSU_CFG_AW-1:0] cfg_adr,
    input  logic [`LSU_XLEN-1:0]   cfg_dat_w,
    output logic [`LSU_XLEN-1:0]   cfg_dat_r,
    output logic                   cfg_ack
);
    import lsu_pkg::*;

    mem_access_t          acc;
    lsu_window_t          win;
    logic                 busy;
    logic                 done;
    logic                 bus_err;
    logic [`LSU_XLEN-1:0] rdata;
    logic                 fault_pulse;
    logic [`LSU_XLEN-1:0] fault_addr;

    // address, alignment and window check
    mem_addr_stage u_addr (
        .op   (op),
        .win  (win),
        .busy (busy),
        .acc  (acc)
    );

    wb_data_port u_port (
        .clk     (clk),
        .arst_n  (arst_n),
        .acc     (acc),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .sel     (sel),
        .dat_w   (dat_w),
        .dat_r   (dat_r),
        .ack     (ack),
        .err     (err),
        .done    (done),
        .bus_err (bus_err),
        .rdata   (rdata),
        .busy    (busy)
    );

    // result register and stall
    mem_wb_stage u_wb (
        .clk         (clk),
        .arst_n      (arst_n),
        .op          (op),
        .acc         (acc),
        .done        (done),
        .bus_err     (bus_err),
        .rdata       (rdata),
        .res         (res),
        .stall       (stall),
        .fault_pulse (fault_pulse),
        .fault_addr  (fault_addr)
    );

    lsu_ctrl_regs u_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .cfg_cyc     (cfg_cyc),
        .cfg_stb     (cfg_stb),
        .cfg_we      (cfg_we),
        .cfg_adr     (cfg_adr),
        .cfg_dat_w   (cfg_dat_w),
        .cfg_dat_r   (cfg_dat_r),
        .cfg_ack     (cfg_ack),
        .fault_pulse (fault_pulse),
        .fault_addr  (fault_addr),
        .win         (win)
    );

endmodule

`default_nettype wire

/* mem_wb_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module mem_wb_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  lsu_pkg::mem_op_t     op,
    input  lsu_pkg::mem_access_t acc,
    input  logic                 done,
    input  logic                 bus_err,
    input  logic [`LSU_XLEN-1:0] rdata,
    output lsu_pkg::mem_result_t res,
    output logic                 stall,
    output logic                 fault_pulse,
    output logic [`LSU_XLEN-1:0] fault_addr
);
    import lsu_pkg::*;

    logic [1:0]           off;
    logic [7:0]           byte_v;
    logic [15:0]          half_v;
    logic [`LSU_XLEN-1:0] load_v;     // extended load value
    logic [`LSU_EXPW-1:0] exp_n;      // merged code
    logic                 has_exc;
    logic                 take;       // register the result this edge

    logic                 valid_q;
    logic [`LSU_RIDX-1:0] rd_q;
    logic [`LSU_XLEN-1:0] data_q;
    logic [`LSU_EXPW-1:0] exp_q;
    logic [`LSU_XLEN-1:0] badv_q;

    assign off = acc.addr[1:0];

    // lane select and extend
    always_comb begin
        byte_v = rdata[{off, 3'b000} +: 8];
        half_v = off[1] ? rdata[31:16] : rdata[15:0];
        case (op.width)
            W_BYTE:  load_v = {{24{op.sign & byte_v[7]}}, byte_v};
            W_HALF:  load_v = {{16{op.sign & half_v[15]}}, half_v};
            default: load_v = rdata;
        endcase
    end

    // acc.exp already holds upstream, ALE and PME in order
    assign exp_n   = (acc.exp != EXC_NONE) ? acc.exp :
                     bus_err               ? EXC_BUS : EXC_NONE;
    assign has_exc = (exp_n != EXC_NONE);

    // faults finish at once, bus ops on done, only once per held op
    assign take  = op.en & ~valid_q & ((acc.exp != EXC_NONE) | done);
    assign stall = op.en & ~valid_q;

    // counted faults exclude codes from upstream
    assign fault_pulse = take & has_exc & (op.exp == EXC_NONE);
    assign fault_addr  = acc.addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= take;   // one cycle, op moves on after it
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            rd_q   <= has_exc ? '0 : op.rd;
            data_q <= (has_exc || op.write) ? '0 : load_v;   // stores return 0
            exp_q  <= exp_n;
            badv_q <= (has_exc && op.exp == EXC_NONE) ? acc.addr : '0;
        end
    end

    assign res = '{
        valid: valid_q,
        rd:    rd_q,
        data:  data_q,
        exp:   exp_q,
        badv:  badv_q
    };

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mem_stage.f \
    --top-module tb_mem_stage --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

# error limit raised so the summary is reached after an assertion failure
out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

/* tb_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module tb_mem_stage;
    import lsu_pkg::*;

    localparam int CLK_NS   = 4;
    localparam int MAX_WAIT = 3;    // wait states from the model, 0 to 3
    localparam int NUM_OPS  = 30;
    localparam int NUM_CFG  = 12;
    localparam int OP_LIMIT = 40;   // cycles per op before giving up

    logic clk = 1'b0;
    logic arst_n = 1'b0;
    mem_op_t op = '0;
    mem_result_t res;
    logic stall, cyc, stb, we, ack = 1'b0, err = 1'b0;
    logic [31:0] adr, dat_w, dat_r = '0;
    logic [3:0] sel;
    logic cfg_cyc = 1'b0, cfg_stb = 1'b0, cfg_we = 1'b0, cfg_ack;
    logic [`LSU_CFG_AW-1:0] cfg_adr = '0;
    logic [31:0] cfg_dat_w = '0, cfg_dat_r;

    logic [31:0] mem [0:255];
    logic [31:0] rng = 32'd33263;
    logic [1:0] wait_left = '0;
    logic [3:0] last_sel = '0;      // sel of the last acked store
    logic cyc_q = 1'b0;             // cyc one edge ago
    int cyc_rises = 0;
    int errors = 0;
    int tests = 0;
    int test_start = 0;
    int faults = 0;                 // expected fault count
    mem_result_t got;
    logic [31:0] rv, w;

    mem_stage_top DUT (.*);

    always #(CLK_NS/2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // extract and extend from a whole word
    function automatic logic [31:0] load_val(input logic [31:0] wd, input mem_width_e wid,
                                             input logic sgn, input logic [1:0] off);
        logic [31:0] s;
        s = wd >> (off * 8);
        if (wid == W_BYTE) return {{24{sgn & s[7]}}, s[7:0]};
        if (wid == W_HALF) return {{16{sgn & s[15]}}, s[15:0]};
        return wd;
    endfunction

    // memory slave with random wait states, err in the top 16 words
    always @(posedge clk) begin
        ack <= 1'b0;
        err <= 1'b0;
        if (cyc && stb && !ack && !err) begin
            if (wait_left == 0) begin
                rng = xorshift(rng);
                wait_left <= rng[1:0];
                if (adr[9:2] >= 8'd240) begin
                    err <= 1'b1;
                end else begin
                    ack <= 1'b1;
                    dat_r <= mem[adr[9:2]];
                    if (we) begin
                        last_sel <= sel;
                        for (int i = 0; i < 4; i++)
                            if (sel[i]) mem[adr[9:2]][i*8 +: 8] <= dat_w[i*8 +: 8];
                    end
                end
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    // count bus cycle starts
    always @(posedge clk) begin
        if (cyc && !cyc_q) begin
            cyc_rises++;
        end
        cyc_q <= cyc;
    end

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s", what);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic check_eq(input string name, input logic [31:0] g, input logic [31:0] e);
        assert (g === e) else begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, g, e);
        end
    endtask

    // one op, result sampled at the falling edge of the valid cycle
    task automatic run_op(input logic wr, input mem_width_e wid, input logic sgn,
                          input logic [4:0] rd, input logic [31:0] a, input logic [31:0] wd,
                          input logic [6:0] ex);
        int n;
        n = 0;
        @(posedge clk);
        op <= '{en: 1'b1, write: wr, width: wid, sign: sgn, rd: rd, base: a - 32'h10,
                imm: 32'h10, wdata: wd, exp: ex};
        do begin
            @(negedge clk);
            n++;
            if (n > OP_LIMIT) timeout_fail("result valid");
        end while (!res.valid);
        got = res;
        @(posedge clk);
        op.en <= 1'b0;
    endtask

    task automatic cfg_access(input logic wr, input logic [2:0] a, input logic [31:0] d);
        int n;
        n = 0;
        @(posedge clk);
        {cfg_cyc, cfg_stb, cfg_we, cfg_adr, cfg_dat_w} <= {2'b11, wr, a, d};
        do begin
            @(negedge clk);
            n++;
            if (n > OP_LIMIT) timeout_fail("config ack");
        end while (!cfg_ack);
        rv = cfg_dat_r;
        @(posedge clk);
        {cfg_cyc, cfg_stb, cfg_we} <= 3'b000;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %s: %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    // faulted op expectations, only a bus error starts a cycle
    task automatic check_fault(input logic [6:0] code, input logic [31:0] badv, input int c0);
        check_eq("res.exp", 32'(got.exp), 32'(code));
        check_eq("res.badv", got.badv, badv);
        check_eq("res.rd", 32'(got.rd), 0);
        check_eq("res.data", got.data, 0);
        if (code != EXC_BUS) check_eq("cyc_rises", cyc_rises - c0, 0);
    endtask

    initial begin
        int c0;
        for (int i = 0; i < 256; i++) mem[i] <= {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        run_op(1'b1, W_WORD, 1'b0, 5'd3, 32'h40, 32'hdeadbeef, 7'h0);
        check_eq("last_sel", 32'(last_sel), 32'hf);
        check_eq("res.exp", 32'(got.exp), 32'(EXC_NONE));
        run_op(1'b0, W_WORD, 1'b0, 5'd5, 32'h40, 32'h0, 7'h0);
        check_eq("res.data", got.data, 32'hdeadbeef);
        check_eq("res.rd", 32'(got.rd), 32'd5);
        check_eq("res.exp", 32'(got.exp), 32'(EXC_NONE));
        finish_test("word");

        mem[32] <= 32'h817f_f280;   // both sign states in every lane
        for (int o = 0; o < 4; o++) begin
            for (int s = 0; s < 2; s++) begin
                run_op(1'b0, W_BYTE, s[0], 5'd7, 32'h80 + o, 32'h0, 7'h0);
                check_eq("res.data", got.data, load_val(mem[32], W_BYTE, s[0], o[1:0]));
                if (o[0] == 1'b0) begin
                    run_op(1'b0, W_HALF, s[0], 5'd8, 32'h80 + o, 32'h0, 7'h0);
                    check_eq("res.data", got.data, load_val(mem[32], W_HALF, s[0], o[1:0]));
                end
            end
        end
        w = mem[33];
        run_op(1'b1, W_BYTE, 1'b0, 5'd0, 32'h85, 32'h0000_007f, 7'h0);
        check_eq("last_sel", 32'(last_sel), 32'b0010);
        check_eq("mem", mem[33], {w[31:16], 8'h7f, w[7:0]});
        run_op(1'b1, W_HALF, 1'b0, 5'd0, 32'h86, 32'h0000_a55a, 7'h0);
        check_eq("last_sel", 32'(last_sel), 32'b1100);
        check_eq("mem", mem[33], {16'ha55a, 8'h7f, w[7:0]});
        finish_test("lanes");

        c0 = cyc_rises;
        run_op(1'b0, W_HALF, 1'b1, 5'd9, 32'h101, 32'h0, 7'h0);
        check_fault(EXC_ALE, 32'h101, c0);
        run_op(1'b1, W_WORD, 1'b0, 5'd9, 32'h102, 32'h1, 7'h0);
        check_fault(EXC_ALE, 32'h102, c0);
        faults += 2;
        finish_test("misalign");

        cfg_access(1'b1, `LSU_CFG_BASE, 32'h100);
        cfg_access(1'b1, `LSU_CFG_MASK, 32'hffff_ff00);
        cfg_access(1'b1, `LSU_CFG_CTRL, 32'h1);
        c0 = cyc_rises;
        run_op(1'b0, W_WORD, 1'b0, 5'd4, 32'h200, 32'h0, 7'h0);
        check_fault(EXC_PME, 32'h200, c0);
        faults++;
        run_op(1'b0, W_WORD, 1'b0, 5'd4, 32'h104, 32'h0, 7'h0);
        check_eq("res.exp", 32'(got.exp), 32'(EXC_NONE));
        check_eq("res.data", got.data, mem[65]);
        cfg_access(1'b0, `LSU_CFG_FCNT, 32'h0);
        check_eq("fcnt", rv, faults);
        cfg_access(1'b0, `LSU_CFG_FADDR, 32'h0);
        check_eq("faddr", rv, 32'h200);
        cfg_access(1'b1, `LSU_CFG_FCNT, 32'h55);
        cfg_access(1'b0, `LSU_CFG_FCNT, 32'h0);
        check_eq("fcnt", rv, faults);
        cfg_access(1'b1, `LSU_CFG_CTRL, 32'h0);
        finish_test("window");

        c0 = cyc_rises;
        run_op(1'b0, W_WORD, 1'b0, 5'd6, 32'h40, 32'h0, 7'h05);
        check_fault(7'h05, 32'h0, c0);
        cfg_access(1'b0, `LSU_CFG_FCNT, 32'h0);
        check_eq("fcnt", rv, faults);
        finish_test("upstream");

        run_op(1'b0, W_WORD, 1'b0, 5'd6, 32'h3c4, 32'h0, 7'h0);
        check_fault(EXC_BUS, 32'h3c4, c0);
        faults++;
        cfg_access(1'b0, `LSU_CFG_FCNT, 32'h0);
        check_eq("fcnt", rv, faults);
        finish_test("bus_err");

        repeat (3) @(posedge clk);
        errors += DUT.u_chk.fails;
        $display("tests %0d, errors %0d, assertion failures %0d", tests, errors,
                 DUT.u_chk.fails);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog sized from the op and config counts
    initial begin
        #((10 + NUM_OPS * (MAX_WAIT + 6) + NUM_CFG * 4 + 200) * CLK_NS);
        $display("watchdog expired, run did not complete");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_mem_stage_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module tb_mem_stage_assertions (
    input logic                 clk,
    input logic                 arst_n,
    input lsu_pkg::mem_op_t     op,
    input lsu_pkg::mem_access_t acc,
    input lsu_pkg::mem_result_t res,
    input logic                 stall,
    input logic                 cyc,
    input logic                 stb,
    input logic                 we,
    input logic [`LSU_XLEN-1:0] adr,
    input logic [`LSU_SELW-1:0] sel,
    input logic [`LSU_XLEN-1:0] dat_w,
    input logic                 ack,
    input logic                 err
);
    int fails = 0;  // read by the testbench summary

    a_stb_cyc: assert property (@(posedge clk) disable iff (!arst_n) stb |-> cyc)
        else begin fails++; $error("stb without cyc"); end

    // wait state keeps the address phase
    a_stable: assert property (@(posedge clk) disable iff (!arst_n)
        cyc && !ack && !err |=> $stable(adr) && $stable(we) && $stable(sel) && $stable(dat_w))
        else begin fails++; $error("bus signals changed in a wait state"); end

    a_no_cyc: assert property (@(posedge clk) disable iff (!arst_n)
        op.en && acc.exp != 0 |=> !cyc)
        else begin fails++; $error("bus cycle for a faulted op"); end

    a_valid_stall: assert property (@(posedge clk) disable iff (!arst_n) res.valid |-> !stall)
        else begin fails++; $error("stall high with result valid"); end

    a_valid_once: assert property (@(posedge clk) disable iff (!arst_n)
        res.valid |=> !res.valid)
        else begin fails++; $error("result valid longer than a cycle"); end

    a_exc_zero: assert property (@(posedge clk) disable iff (!arst_n)
        res.exp != 0 |-> res.rd == 0 && res.data == 0)
        else begin fails++; $error("rd or data nonzero with exception"); end

endmodule

bind mem_stage_top tb_mem_stage_assertions u_chk (
    .clk(clk), .arst_n(arst_n), .op(op), .acc(acc), .res(res), .stall(stall),
    .cyc(cyc), .stb(stb), .we(we), .adr(adr), .sel(sel), .dat_w(dat_w),
    .ack(ack), .err(err)
);

`default_nettype wire

/* wb_data_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module wb_data_port (
    input  logic                 clk,
    input  logic                 arst_n,
    input  lsu_pkg::mem_access_t acc,
    output logic                 cyc,
    output logic                 stb,
    output logic                 we,
    output logic [`LSU_XLEN-1:0] adr,
    output logic [`LSU_SELW-1:0] sel,
    output logic [`LSU_XLEN-1:0] dat_w,
    input  logic [`LSU_XLEN-1:0] dat_r,
    input  logic                 ack,
    input  logic                 err,
    output logic                 done,     // access finished this cycle
    output logic                 bus_err,
    output logic [`LSU_XLEN-1:0] rdata,
    output logic                 busy
);
    import lsu_pkg::*;

    wb_state_e state_q;
    wb_state_e state_n;
    logic      start;     // launch a cycle on the next edge
    logic      end_cyc;   // slave replied

    assign start   = (state_q == WB_IDLE) & acc.go;
    assign end_cyc = (state_q == WB_CYCLE) & (ack | err);

    always_comb begin
        state_n = state_q;
        case (state_q)
            WB_IDLE: begin
                if (acc.go) begin
                    state_n = WB_CYCLE;
                end
            end
            WB_CYCLE: begin
                if (ack || err) begin
                    state_n = WB_DONE;   // any number of wait states before this
                end
            end
            default: begin
                state_n = WB_IDLE;       // result registers during done
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= WB_IDLE;
        end else begin
            state_q <= state_n;
        end
    end

    // address phase captured once, stable through wait states
    always_ff @(posedge clk) begin
        if (start) begin
            we    <= acc.write;
            adr   <= acc.addr;
            sel   <= acc.sel;
            dat_w <= acc.wdata;
        end
    end

    assign cyc = (state_q == WB_CYCLE);
    assign stb = (state_q == WB_CYCLE);   // classic, no pipelined strobes

    // reply handed over in the ack cycle
    assign done    = end_cyc;
    assign bus_err = end_cyc & err;
    assign rdata   = (end_cyc & ~err) ? dat_r : '0;

    assign busy = (state_q != WB_IDLE);   // cycle plus result cycle

endmodule

`default_nettype wire
